/* sim.f */
+incdir+common
common/vnu_ctrl_pkg.sv
ib_load/ib_load_tracker.sv
logic/decode_sched_fsm.sv
logic/stage_strobe_gen.sv
logic/vnu_control_unit.sv
test/tb_vnu_control_unit.sv

/* Makefile */
SIM      = verilator
TOP      = tb_vnu_control_unit
FILELIST = sim.f
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# the run exits non-zero when the testbench stops on a failure
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* test/tb_vnu_control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vnu_ctrl_macros.svh"

module tb_vnu_control_unit;
	import vnu_ctrl_pkg::*;

	localparam int FN         = `VNU_FUNC_NUM;
	localparam int LAST       = `LAYER_NUM - 1;
	localparam int MAX_CYCLES = 2000; // room for 16 layers of up to 120 cycles

	logic         read_clk = 1'b0;
	logic         rstn;
	logic         fsm_en_i;
	logic         termination_i;
	func_vec_t    vn_iter_update_i = '0; // driven by the write FSM model
	sched_state_t state_o;
	layer_vec_t   layer_cnt_o;
	logic         last_layer_o;
	func_vec_t    vnu_wr_o;
	func_vec_t    vnu_rd_o;
	logic         dnu_rd_o;
	logic         vnu_update_pend_o;
	logic         v2c_src_o;
	logic         v2c_bs_en_o;
	logic         v2c_pa_en_o;
	logic         v2c_mem_we_o;
	logic         layer_finish_o;
	logic         hard_decision_done_o;

	vnu_control_unit uut (.*);

	always #4 read_clk = ~read_clk; // 8 ns period

	//////////////////////////////////////////////////////////////////////
	// reference functions
	//////////////////////////////////////////////////////////////////////
	function automatic sched_state_t next_state(sched_state_t s, stage_idx_t stg, logic settled,
	                                            logic en, logic term);
		if (!en || term)
			return INIT_LOAD; // held off or restarted
		case (s)
			INIT_LOAD       : return CH_FETCH;
			CH_FETCH        : return MEM_FETCH;
			MEM_FETCH       : begin
				if (int'(stg) != `MEM_RD_LEVEL - 1)
					return MEM_FETCH;
				return settled ? VNU_PIPE : VNU_IB_RAM_PEND;
			end
			VNU_IB_RAM_PEND : return settled ? VNU_PIPE : VNU_IB_RAM_PEND;
			VNU_PIPE        : return (int'(stg) == `VNU_PIPE_LEVEL - 2) ? VNU_OUT : VNU_PIPE;
			VNU_OUT         : return BS_WB;
			BS_WB           : return (int'(stg) == `PERMUTATION_LEVEL - 1) ? PAGE_ALIGN : BS_WB;
			PAGE_ALIGN      : return MEM_WB;
			MEM_WB          : return IDLE;
			default         : return CH_FETCH; // IDLE opens the next layer
		endcase
	endfunction

	// VNU_OUT keeps counting from VNU_PIPE as the final vnu stage
	function automatic stage_idx_t next_stage(sched_state_t s, sched_state_t n, stage_idx_t stg);
		if ((s == n && s inside {MEM_FETCH, VNU_PIPE, BS_WB}) || (s == VNU_PIPE && n == VNU_OUT))
			return stg + 1'b1;
		return '0;
	endfunction

	// {vnu_rd, dnu, pend, src, bs, pa, we, layer_finish, hard_decision}
	function automatic logic [FN+7:0] strobe_ref(sched_state_t s, stage_idx_t stg, logic last,
	                                             logic settled);
		func_vec_t rd;
		for (int j = 0; j < FN; j++)
			rd[j] = (s == VNU_PIPE || s == VNU_OUT) && (int'(stg) / `VNU_FUNC_CYCLE == j);
		return {rd, s inside {BS_WB, PAGE_ALIGN}, s inside {MEM_FETCH, VNU_IB_RAM_PEND} && !settled,
		        s == MEM_FETCH && int'(stg) == `MEM_RD_LEVEL - 1, s == BS_WB && int'(stg) == 0,
		        s == PAGE_ALIGN, s == MEM_WB, s == IDLE, s == MEM_WB && last};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Testbench failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("ERROR at %0t: %s", $time, reason);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model of the scheduler and the ib-ram handshake
	//////////////////////////////////////////////////////////////////////
	sched_state_t    m_state;
	sched_state_t    m_next;
	stage_idx_t      m_stage;
	layer_vec_t      m_layer;
	func_vec_t       m_pipe_start; // one cycle after a read window closes
	func_vec_t       m_open;
	func_vec_t       m_ack;
	func_vec_t       m_settled;
	int              m_age [FN];   // cycles since the request rose
	logic [FN+7:0]   exp_strb;     // strobes due this cycle

	always_comb begin
		for (int j = 0; j < FN; j++)
			m_settled[j] = !m_open[j] || (m_ack[j] && m_age[j] >= `LOAD_HANDSHAKE_LATENCY);
		m_next = next_state(m_state, m_stage, &m_settled, fsm_en_i, termination_i);
	end

	always @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			m_state      <= INIT_LOAD;
			m_stage      <= '0;
			m_layer      <= layer_vec_t'(1);
			m_pipe_start <= '0;
			m_open       <= '0;
			m_ack        <= '0;
			exp_strb     <= '0;
			for (int j = 0; j < FN; j++)
				m_age[j] <= 0;
		end else begin
			m_state  <= m_next;
			m_stage  <= next_stage(m_state, m_next, m_stage);
			exp_strb <= strobe_ref(m_state, m_stage, m_layer[LAST], &m_settled);
			if (m_state == IDLE)
				m_layer <= {m_layer[LAST-1:0], m_layer[LAST]}; // one step per layer
			for (int j = 0; j < FN; j++) begin
				m_pipe_start[j] <= m_layer[LAST] && (m_state inside {VNU_PIPE, VNU_OUT}) &&
				                   int'(m_stage) == `VNU_FUNC_CYCLE*j + `VNU_FUNC_CYCLE - 1;
				if ((m_state == INIT_LOAD && m_next == CH_FETCH) || m_pipe_start[j]) begin
					m_open[j] <= 1'b1; // fresh request replaces one still open
					m_ack[j]  <= 1'b0;
					m_age[j]  <= 0;
				end else if (m_open[j]) begin
					if (m_settled[j])
						m_open[j] <= 1'b0;
					if (vn_iter_update_i[j])
						m_ack[j] <= 1'b1; // acks with no open load are dropped
					m_age[j] <= m_age[j] + 1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// comparer at mid-cycle where every output is stable
	//////////////////////////////////////////////////////////////////////
	sched_state_t prev_state = INIT_LOAD;
	func_vec_t    wr_prev    = '0;
	int           rise_age [FN] = '{default: 100}; // large until a first request
	int           pend_cycles   = 0;

	always @(negedge read_clk) begin
		check_value("state_o", 32'(state_o), 32'(m_state));
		check_value("layer_cnt_o", 32'(layer_cnt_o), 32'(m_layer));
		check_value("last_layer_o", 32'(last_layer_o), 32'(m_layer[LAST]));
		check_value("vnu_wr_o", 32'(vnu_wr_o), 32'(m_open & ~m_ack));
		check_value("vnu_rd_o", 32'(vnu_rd_o), 32'(exp_strb[FN+7:8]));
		check_value("dnu_rd_o", 32'(dnu_rd_o), 32'(exp_strb[7]));
		check_value("vnu_update_pend_o", 32'(vnu_update_pend_o), 32'(exp_strb[6]));
		check_value("v2c_src_o", 32'(v2c_src_o), 32'(exp_strb[5]));
		check_value("v2c_bs_en_o", 32'(v2c_bs_en_o), 32'(exp_strb[4]));
		check_value("v2c_pa_en_o", 32'(v2c_pa_en_o), 32'(exp_strb[3]));
		check_value("v2c_mem_we_o", 32'(v2c_mem_we_o), 32'(exp_strb[2]));
		check_value("layer_finish_o", 32'(layer_finish_o), 32'(exp_strb[1]));
		check_value("hard_decision_done_o", 32'(hard_decision_done_o), 32'(exp_strb[0]));
		for (int j = 0; j < FN; j++)
			rise_age[j] = (vnu_wr_o[j] && !wr_prev[j]) ? 0 : rise_age[j] + 1;
		if (state_o == VNU_IB_RAM_PEND) begin
			pend_cycles++;
			check_value("vnu_update_pend_o", 32'(vnu_update_pend_o), 32'd1); // stall flagged
		end
		if (state_o == VNU_PIPE && prev_state != VNU_PIPE) begin
			check_value("vnu_wr_o", 32'(vnu_wr_o), 32'd0); // no request left open
			// the entry decision comes at least the handshake latency after the rise
			for (int j = 0; j < FN; j++) begin
				if (rise_age[j] <= `LOAD_HANDSHAKE_LATENCY)
					abort_run($sformatf("VNU_PIPE entered %0d cycles after vnu_wr_o[%0d] rose",
					                    rise_age[j], j));
			end
		end
		prev_state = state_o;
		wr_prev    = vnu_wr_o;
	end

	//////////////////////////////////////////////////////////////////////
	// write FSM model, timeout and stimulus
	//////////////////////////////////////////////////////////////////////
	integer    seed       = 32'h3538;
	logic      slow_phase = 1'b0;
	int        wait_cnt [FN] = '{default: 0};
	func_vec_t ack_v;
	int        cycles = 0;

	always @(posedge read_clk) begin
		#1;
		ack_v = '0;
		for (int j = 0; j < FN; j++) begin
			if (wait_cnt[j] > 0) begin
				wait_cnt[j]--;
				ack_v[j] = (wait_cnt[j] == 0); // one-cycle answer
			end else if (vnu_wr_o[j]) begin
				if (slow_phase)
					wait_cnt[j] = 10 + int'($unsigned($random(seed)) % 21);
				else
					wait_cnt[j] = 1 + int'($unsigned($random(seed)) % 4);
			end
		end
		vn_iter_update_i = ack_v;
	end

	always @(posedge read_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			abort_run($sformatf("timeout after %0d cycles", MAX_CYCLES));
	end

	task automatic wait_layers(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge read_clk);
			#1;
			if (layer_finish_o)
				seen++;
		end
	endtask

	initial begin
		rstn          = 1'b0;
		fsm_en_i      = 1'b0;
		termination_i = 1'b0;
		repeat (4) @(posedge read_clk);
		#1 rstn = 1'b1;
		repeat (3) @(posedge read_clk); // out of reset but still disabled
		#1 fsm_en_i = 1'b1;
		wait_layers(2 * `LAYER_NUM); // fast acks
		@(negedge read_clk);
		slow_phase = 1'b1;
		wait_layers(2 * `LAYER_NUM); // pipe loads now stall the next first layer
		@(negedge read_clk);
		slow_phase = 1'b0;
		@(posedge read_clk);
		#1;
		while (state_o != VNU_PIPE) begin
			@(posedge read_clk);
			#1;
		end
		termination_i = 1'b1; // restart in the middle of the vnu pipe
		@(posedge read_clk);
		#1 termination_i = 1'b0;
		check_value("state_o", 32'(state_o), 32'(INIT_LOAD));
		@(posedge read_clk);
		#1;
		check_value("vnu_wr_o", 32'(vnu_wr_o), 32'({FN{1'b1}})); // initial load again
		wait_layers(`LAYER_NUM);
		if (pend_cycles == 0)
			abort_run("no VNU_IB_RAM_PEND stall was seen");
		else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* logic/vnu_control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module vnu_control_unit (
	input  wire                          read_clk,
	input  wire                          rstn,
	input  wire                          fsm_en_i,
	input  wire                          termination_i,
	input  wire vnu_ctrl_pkg::func_vec_t vn_iter_update_i, // write FSM acks
	output vnu_ctrl_pkg::sched_state_t   state_o,
	output vnu_ctrl_pkg::layer_vec_t     layer_cnt_o,
	output logic                         last_layer_o,
	output vnu_ctrl_pkg::func_vec_t      vnu_wr_o,
	output vnu_ctrl_pkg::func_vec_t      vnu_rd_o,
	output logic                         dnu_rd_o,
	output logic                         vnu_update_pend_o,
	output logic                         v2c_src_o,
	output logic                         v2c_bs_en_o,
	output logic                         v2c_pa_en_o,
	output logic                         v2c_mem_we_o,
	output logic                         layer_finish_o,
	output logic                         hard_decision_done_o
);
	import vnu_ctrl_pkg::*;

	stage_idx_t stage_idx;
	func_vec_t  pipe_load_start; // last-layer refill, per function
	logic       init_load_start;
	logic       loads_settled;

	// ib-ram write handshake
	ib_load_tracker u_ib_load_tracker (
		.read_clk          (read_clk),
		.rstn              (rstn),
		.init_load_start_i (init_load_start),
		.pipe_load_start_i (pipe_load_start),
		.vn_iter_update_i  (vn_iter_update_i),
		.vnu_wr_o          (vnu_wr_o),
		.loads_settled_o   (loads_settled)
	);

	// scheduler core
	decode_sched_fsm u_decode_sched_fsm (
		.read_clk          (read_clk),
		.rstn              (rstn),
		.fsm_en_i          (fsm_en_i),
		.termination_i     (termination_i),
		.loads_settled_i   (loads_settled),
		.state_o           (state_o),
		.stage_idx_o       (stage_idx),
		.layer_cnt_o       (layer_cnt_o),
		.last_layer_o      (last_layer_o),
		.init_load_start_o (init_load_start),
		.pipe_load_start_o (pipe_load_start)
	);

	// datapath strobes
	stage_strobe_gen u_stage_strobe_gen (
		.read_clk             (read_clk),
		.rstn                 (rstn),
		.state_i              (state_o),
		.stage_idx_i          (stage_idx),
		.last_layer_i         (last_layer_o),
		.loads_settled_i      (loads_settled),
		.vnu_rd_o             (vnu_rd_o),
		.dnu_rd_o             (dnu_rd_o),
		.vnu_update_pend_o    (vnu_update_pend_o),
		.v2c_src_o            (v2c_src_o),
		.v2c_bs_en_o          (v2c_bs_en_o),
		.v2c_pa_en_o          (v2c_pa_en_o),
		.v2c_mem_we_o         (v2c_mem_we_o),
		.layer_finish_o       (layer_finish_o),
		.hard_decision_done_o (hard_decision_done_o)
	);

endmodule

`default_nettype wire

/* logic/stage_strobe_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vnu_ctrl_macros.svh"

module stage_strobe_gen (
	input  wire                             read_clk,
	input  wire                             rstn,
	input  wire vnu_ctrl_pkg::sched_state_t state_i,
	input  wire vnu_ctrl_pkg::stage_idx_t   stage_idx_i,
	input  wire                             last_layer_i,
	input  wire                             loads_settled_i,
	output vnu_ctrl_pkg::func_vec_t         vnu_rd_o,     // vnu read window per function
	output logic                            dnu_rd_o,
	output logic                            vnu_update_pend_o,
	output logic                            v2c_src_o,    // fetched v2c source valid
	output logic                            v2c_bs_en_o,
	output logic                            v2c_pa_en_o,
	output logic                            v2c_mem_we_o,
	output logic                            layer_finish_o,
	output logic                            hard_decision_done_o
);
	import vnu_ctrl_pkg::*;

	func_vec_t rd_d;
	logic      vnu_window;
	logic      fetch_or_pend; // states where a stall can be flagged

	assign vnu_window    = (state_i == VNU_PIPE) || (state_i == VNU_OUT);
	assign fetch_or_pend = (state_i == MEM_FETCH) || (state_i == VNU_IB_RAM_PEND);

	// function j reads during stages 3j .. 3j+2
	genvar j;
	generate
		for (j = 0; j < `VNU_FUNC_NUM; j++) begin : g_rd
			assign rd_d[j] = vnu_window &&
			                 (stage_idx_i >= stage_idx_t'(`VNU_FUNC_CYCLE*j)) &&
			                 (stage_idx_i <= stage_idx_t'(`VNU_FUNC_CYCLE*j + `VNU_FUNC_CYCLE-1));
		end
	endgenerate

	//////////////////////////////////////////////////////////////////////
	// strobe registers, one cycle behind the state
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			vnu_rd_o             <= '0;
			dnu_rd_o             <= 1'b0;
			vnu_update_pend_o    <= 1'b0;
			v2c_src_o            <= 1'b0;
			v2c_bs_en_o          <= 1'b0;
			v2c_pa_en_o          <= 1'b0;
			v2c_mem_we_o         <= 1'b0;
			layer_finish_o       <= 1'b0;
			hard_decision_done_o <= 1'b0;
		end else begin
			vnu_rd_o          <= rd_d;
			dnu_rd_o          <= (state_i == BS_WB) || (state_i == PAGE_ALIGN); // dnu runs BS_WB..PA
			vnu_update_pend_o <= fetch_or_pend && !loads_settled_i;
			v2c_src_o         <= (state_i == MEM_FETCH) &&
			                     (stage_idx_i == stage_idx_t'(`MEM_RD_LEVEL - 1));
			v2c_bs_en_o       <= (state_i == BS_WB) && (stage_idx_i == '0); // first shift cycle only
			v2c_pa_en_o       <= (state_i == PAGE_ALIGN);
			v2c_mem_we_o      <= (state_i == MEM_WB);
			layer_finish_o    <= (state_i == IDLE);
			hard_decision_done_o <= (state_i == MEM_WB) && last_layer_i; // once per iteration
		end
	end

	// v2c path steps are strictly sequential
	a_v2c_onehot : assert property (
		@(posedge read_clk) disable iff (!rstn)
		$onehot0({v2c_src_o, v2c_bs_en_o, v2c_pa_en_o, v2c_mem_we_o})
	) else $error("overlapping v2c strobes");

endmodule

`default_nettype wire

/* logic/decode_sched_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vnu_ctrl_macros.svh"

module decode_sched_fsm (
	input  wire                        read_clk,
	input  wire                        rstn,
	input  wire                        fsm_en_i,
	input  wire                        termination_i,   // frame decoded, restart
	input  wire                        loads_settled_i, // from the ib-ram tracker
	output vnu_ctrl_pkg::sched_state_t state_o,
	output vnu_ctrl_pkg::stage_idx_t   stage_idx_o,
	output vnu_ctrl_pkg::layer_vec_t   layer_cnt_o,
	output logic                       last_layer_o,
	output logic                       init_load_start_o,
	output vnu_ctrl_pkg::func_vec_t    pipe_load_start_o
);
	import vnu_ctrl_pkg::*;

	// last stage index of each multi-cycle state
	localparam stage_idx_t FETCH_LAST = stage_idx_t'(`MEM_RD_LEVEL - 1);
	localparam stage_idx_t PIPE_LAST  = stage_idx_t'(`VNU_PIPE_LEVEL - 2); // VNU_OUT takes the last
	localparam stage_idx_t BS_LAST    = stage_idx_t'(`PERMUTATION_LEVEL - 1);

	sched_state_t state_q;
	sched_state_t state_d;
	stage_idx_t   stage_q;
	stage_idx_t   stage_d;
	layer_vec_t   layer_q;    // one-hot
	func_vec_t    pipe_hit;   // read window of function j closes this cycle
	func_vec_t    pipe_start_q;
	logic         vnu_window; // vnu read stages are live

	//////////////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		state_d = state_q;
		if (!fsm_en_i || termination_i) begin
			state_d = INIT_LOAD; // held off or new frame
		end else begin
			case (state_q)
				INIT_LOAD : state_d = CH_FETCH;
				CH_FETCH  : state_d = MEM_FETCH;
				MEM_FETCH : begin
					if (stage_q == FETCH_LAST)
						state_d = loads_settled_i ? VNU_PIPE : VNU_IB_RAM_PEND;
				end
				VNU_IB_RAM_PEND : begin
					if (loads_settled_i)
						state_d = VNU_PIPE; // ib-rams are up to date
				end
				VNU_PIPE : begin
					if (stage_q == PIPE_LAST)
						state_d = VNU_OUT;
				end
				VNU_OUT : state_d = BS_WB;
				BS_WB : begin
					if (stage_q == BS_LAST)
						state_d = PAGE_ALIGN;
				end
				PAGE_ALIGN : state_d = MEM_WB;
				MEM_WB     : state_d = IDLE;
				IDLE       : state_d = CH_FETCH; // next layer
				default    : state_d = INIT_LOAD;
			endcase
		end
	end

	// stage counts only inside multi-cycle states, VNU_OUT carries on from VNU_PIPE
	always_comb begin
		stage_d = '0;
		if ((state_q == MEM_FETCH || state_q == VNU_PIPE || state_q == BS_WB) &&
		    (state_d == state_q || state_d == VNU_OUT))
			stage_d = stage_q + 1'b1;
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= INIT_LOAD;
			stage_q <= '0;
		end else begin
			state_q <= state_d;
			stage_q <= stage_d;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// layer counter and ib-ram load starts
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			layer_q <= layer_vec_t'(1);
		else if (state_q == IDLE)
			layer_q <= {layer_q[`LAYER_NUM-2:0], layer_q[`LAYER_NUM-1]}; // rotate
	end

	assign vnu_window = (state_q == VNU_PIPE) || (state_q == VNU_OUT);

	genvar j;
	generate
		for (j = 0; j < `VNU_FUNC_NUM; j++) begin : g_pipe_hit
			// stage 3j+2 is the last read of function j
			assign pipe_hit[j] = vnu_window && last_layer_o &&
			                     (stage_q == stage_idx_t'(`VNU_FUNC_CYCLE*j + `VNU_FUNC_CYCLE-1));
		end
	endgenerate

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			pipe_start_q <= '0;
		else
			pipe_start_q <= pipe_hit; // one-cycle pulse
	end

	assign init_load_start_o = (state_q == INIT_LOAD) && (state_d == CH_FETCH);
	assign pipe_load_start_o = pipe_start_q;

	assign state_o      = state_q;
	assign stage_idx_o  = stage_q;
	assign layer_cnt_o  = layer_q;
	assign last_layer_o = layer_q[`LAYER_NUM-1];

	// vnu pipe must never start on stale ib-ram contents
	a_pipe_entry_settled : assert property (
		@(posedge read_clk) disable iff (!rstn)
		(state_q == VNU_PIPE && $past(state_q) != VNU_PIPE) |-> $past(loads_settled_i)
	) else $error("VNU_PIPE entered with ib-ram loads open");

endmodule

`default_nettype wire

/* ib_load/ib_load_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vnu_ctrl_macros.svh"

module ib_load_tracker (
	input  wire                          read_clk,
	input  wire                          rstn,
	input  wire                          init_load_start_i, // all functions at once
	input  wire vnu_ctrl_pkg::func_vec_t pipe_load_start_i, // last layer, per function
	input  wire vnu_ctrl_pkg::func_vec_t vn_iter_update_i,  // ack pulses, write FSMs
	output vnu_ctrl_pkg::func_vec_t      vnu_wr_o,          // update request
	output logic                         loads_settled_o    // nothing left in flight
);
	import vnu_ctrl_pkg::*;

	// counter saturates at the handshake latency
	localparam int CNT_W = $clog2(`LOAD_HANDSHAKE_LATENCY + 1);

	func_vec_t settled; // per function, no open load

	//////////////////////////////////////////////////////////////////////
	// one request/ack channel per lookup function
	//////////////////////////////////////////////////////////////////////
	genvar j;
	generate
		for (j = 0; j < `VNU_FUNC_NUM; j++) begin : g_func
			logic             open_q;    // load requested, not yet settled
			logic             ack_q;     // write FSM answered
			logic [CNT_W-1:0] lat_cnt_q; // cycles since the request rose
			logic             start;
			logic             lat_done;

			assign start    = init_load_start_i | pipe_load_start_i[j];
			assign lat_done = (lat_cnt_q >= CNT_W'(`LOAD_HANDSHAKE_LATENCY));

			// settled needs both the ack and the minimum latency
			assign settled[j] = ~open_q | (ack_q & lat_done);

			// request stays up until the ack pulse has been seen
			assign vnu_wr_o[j] = open_q & ~ack_q;

			always_ff @(posedge read_clk or negedge rstn) begin
				if (!rstn) begin
					open_q    <= 1'b0;
					ack_q     <= 1'b0;
					lat_cnt_q <= '0;
				end else if (start) begin // new load, restarts one still open
					open_q    <= 1'b1;
					ack_q     <= 1'b0;
					lat_cnt_q <= '0;
				end else if (open_q) begin
					if (settled[j])
						open_q <= 1'b0; // handshake closed
					if (vn_iter_update_i[j])
						ack_q <= 1'b1; // pulse only counts with a load open
					if (!lat_done)
						lat_cnt_q <= lat_cnt_q + 1'b1;
				end
			end

			// a request is only ever withdrawn by the write FSM's answer
			a_wr_fall_acked : assert property (
				@(posedge read_clk) disable iff (!rstn)
				$fell(vnu_wr_o[j]) |-> $past(vn_iter_update_i[j])
			) else $error("vnu_wr_o[%0d] dropped without ack", j);
		end
	endgenerate

	assign loads_settled_o = &settled; // scheduler may enter VNU_PIPE

endmodule

`default_nettype wire

/* common/vnu_ctrl_pkg.sv */
`default_nettype none

`include "vnu_ctrl_macros.svh"

package vnu_ctrl_pkg;

	// scheduler states, encoded in pass order
	typedef enum logic [3:0] {
		INIT_LOAD       = 4'd0, // kicks off the ib-ram initial load
		CH_FETCH        = 4'd1, // channel message fetch
		MEM_FETCH       = 4'd2, // c2v memory read, MEM_RD_LEVEL cycles
		VNU_IB_RAM_PEND = 4'd3, // stall until every ib-ram update settled
		VNU_PIPE        = 4'd4,
		VNU_OUT         = 4'd5, // last vnu stage
		BS_WB           = 4'd6, // barrel shift of the v2c messages
		PAGE_ALIGN      = 4'd7,
		MEM_WB          = 4'd8, // v2c write back
		IDLE            = 4'd9  // layer boundary
	} sched_state_t;

	// one bit per vnu lookup function
	typedef logic [`VNU_FUNC_NUM-1:0] func_vec_t;

	// one-hot layer, bit 0 is the first layer
	typedef logic [`LAYER_NUM-1:0] layer_vec_t;

	// cycle index inside MEM_FETCH, VNU_PIPE/VNU_OUT and BS_WB
	typedef logic [`STAGE_W-1:0] stage_idx_t;

endpackage

`default_nettype wire

/* common/vnu_ctrl_macros.svh */
`ifndef VNU_CTRL_MACROS_SVH
`define VNU_CTRL_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// decoder geometry
//////////////////////////////////////////////////////////////////////
`define VNU_FUNC_NUM 2 // vnu 2-lut functions, one ib-ram each
`define LAYER_NUM 3 // layers per decoding iteration

//////////////////////////////////////////////////////////////////////
// pipeline depths, all in read_clk cycles
//////////////////////////////////////////////////////////////////////
`define VNU_FUNC_CYCLE 3 // stages spent in one lookup function
`define VN_PIPE_BUBBLE 0 // halt slots inside the vnu pipe

// the last vnu stage is shared with the output register
`define VNU_PIPE_LEVEL (2*`VNU_FUNC_CYCLE+`VN_PIPE_BUBBLE)

`define MEM_RD_LEVEL 2 // memory fetch takes two cycles
`define PERMUTATION_LEVEL 2 // barrel shifter latency

// request rise to settled, never shorter than this
`define LOAD_HANDSHAKE_LATENCY 3

// stage index inside multi-cycle states, must hold VNU_PIPE_LEVEL-1
`define STAGE_W 3

`endif
